/* Makefile */
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
verilog/core_pkg.sv
verilog/core_ifs.sv
verilog/instr_fetch.sv
verilog/instr_decode.sv
verilog/data_path.sv
verilog/io_port.sv
verilog/core_top.sv
tb/core_assertions.sv
tb/core_tb.sv

/* tb/core_assertions.sv */
/*
 * Core assertions
 * Four-phase handshake, request hold and memory exclusion rules
 */
`timescale 1ns/1ps

module core_assertions import core_pkg::*; (
	input logic                 clk,
	input logic                 rst,
	input logic                 io_req,
	input logic                 io_ack,
	input logic                 io_wr,
	input logic [IO_ADDR_W-1:0] io_addr,
	input logic [DATA_W-1:0]    io_wdata,
	input logic [IADDR_W-1:0]   instr_addr,
	input logic                 mem_wr
);

	// Handshake phases --------------------

	a_req_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(io_req) |-> $past(io_ack))
		else $error("io_req fell without io_ack");

	a_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(io_req) |-> !$past(io_ack))
		else $error("io_req rose while io_ack was high");

	// Held while a request is open
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		io_req && $past(io_req) |-> $stable(io_addr) && $stable(io_wr) && $stable(io_wdata))
		else $error("I/O request fields changed during the request");

	a_pc_hold: assert property (@(posedge clk) disable iff (rst)
		io_req && $past(io_req) |-> $stable(instr_addr))
		else $error("instr_addr moved during an I/O request");

	a_mem_excl: assert property (@(posedge clk) disable iff (rst)
		!(mem_wr && io_req))
		else $error("mem_wr high together with io_req");

endmodule

bind core_top core_assertions u_assert (.*);

/* tb/core_tb.sv */
/*
 * Core testbench
 * ROM, RAM and I/O responder models around the core, a table of
 * operand pairs applied in a loop and checks on every port transfer
 */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

	localparam int N_ROWS   = 8;
	localparam int N_XFER   = 8;
	localparam int WAIT_MAX = 200;

	logic                 clk;
	logic                 rst;
	logic [IADDR_W-1:0]   instr_addr;
	logic [INSTR_W-1:0]   instr;
	logic [DADDR_W-1:0]   mem_addr;
	logic [DATA_W-1:0]    mem_wdata;
	logic                 mem_wr;
	logic [DATA_W-1:0]    mem_rdata;
	logic                 io_req;
	logic                 io_wr;
	logic [IO_ADDR_W-1:0] io_addr;
	logic [DATA_W-1:0]    io_wdata;
	logic [DATA_W-1:0]    io_rdata;
	logic                 io_ack;

	int n_fail;
	int n_timeout;
	int n_stray;
	int seed;
	int cycle = 0;

	logic [INSTR_W-1:0] rom [1 << IADDR_W];
	logic [DATA_W-1:0]  ram [1 << DADDR_W];

	// Stimulus table --------------------
	// Operands a, b and the port 5 value, 2 when a equals b
	logic [DATA_W-1:0] tab_a [N_ROWS] = '{32'h0000_0005, 32'h0000_0000, 32'hffff_ffff,
		32'hffff_ffff, 32'h1234_5678, 32'h0000_0000, 32'h8000_0000, 32'hdead_beef};
	logic [DATA_W-1:0] tab_b [N_ROWS] = '{32'h0000_0003, 32'h0000_0000, 32'h0000_0001,
		32'hffff_ffff, 32'h9abc_def0, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0000};
	logic [DATA_W-1:0] tab_p5 [N_ROWS] = '{32'd1, 32'd2, 32'd1, 32'd2, 32'd1, 32'd1, 32'd2, 32'd1};

	// Transfers of one pass: two reads then six writes
	logic                 xfer_wr   [N_XFER] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
	logic [IO_ADDR_W-1:0] xfer_port [N_XFER] = '{3'd0, 3'd1, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5};
	logic [DATA_W-1:0]    xfer_val  [N_XFER];

	core_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.instr_addr (instr_addr),
		.instr      (instr),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wr     (mem_wr),
		.mem_rdata  (mem_rdata),
		.io_req     (io_req),
		.io_wr      (io_wr),
		.io_addr    (io_addr),
		.io_wdata   (io_wdata),
		.io_rdata   (io_rdata),
		.io_ack     (io_ack)
	);

	always #2 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// Memory models --------------------

	assign instr     = rom[instr_addr];
	assign mem_rdata = ram[mem_addr];

	// Refilled during reset, only mem[1] and mem[2] are program data
	always @(posedge clk) begin
		if (rst) begin
			n_stray <= 0;
			for (int i = 0; i < (1 << DADDR_W); i++)
				ram[i] <= 32'hc0de_0000 | DATA_W'(i);
		end else if (mem_wr) begin
			ram[mem_addr] <= mem_wdata;
			if (mem_addr != DADDR_W'(1) && mem_addr != DADDR_W'(2)) begin
				$display("[FAIL] mem_addr: write to 0x%h, expected 0x001 or 0x002", mem_addr);
				n_stray <= n_stray + 1;
			end
		end
	end

	function automatic logic [INSTR_W-1:0] encode(input logic [OPCODE_W-1:0] op, input int arg);
		return {op, OPERAND_W'(arg)};
	endfunction

	// mem[1] op mem[2] into acc, four words from addr
	task automatic put_binop(input int addr, input logic [OPCODE_W-1:0] op);
		rom[addr]     = encode(OP_LOD, 1);
		rom[addr + 1] = encode(OP_PSH, 0);
		rom[addr + 2] = encode(OP_LOD, 2);
		rom[addr + 3] = encode(op, 0);
	endtask

	task automatic load_program();
		for (int i = 0; i < (1 << IADDR_W); i++)
			rom[i] = encode(OP_NOP, 0);
		// Read a and b, keep them in RAM
		rom[0] = encode(OP_INN, 0);
		rom[1] = encode(OP_SET, 1);
		rom[2] = encode(OP_INN, 1);
		rom[3] = encode(OP_SET, 2);
		put_binop(4, OP_ADD);
		rom[8] = encode(OP_OUT, 0);
		put_binop(9, OP_SUB);
		rom[13] = encode(OP_OUT, 1);
		put_binop(14, OP_XOR);
		rom[18] = encode(OP_OUT, 2);
		rom[19] = encode(OP_CAL, 40);
		put_binop(20, OP_AND);
		rom[24] = encode(OP_OUT, 4);
		// Zero test on a-b
		put_binop(25, OP_SUB);
		rom[29] = encode(OP_JIZ, 33);
		rom[30] = encode(OP_LDK, 1);
		rom[31] = encode(OP_OUT, 5);
		rom[32] = encode(OP_JMP, 0);
		rom[33] = encode(OP_LDK, 2);
		rom[34] = encode(OP_OUT, 5);
		rom[35] = encode(OP_JMP, 0);
		// Subroutine, a|b to port 3
		put_binop(40, OP_ORR);
		rom[44] = encode(OP_OUT, 3);
		rom[45] = encode(OP_RET, 0);
	endtask

	// Compare tasks --------------------

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			n_fail++;
		end
	endtask

	task automatic check_port(input string name, input logic [IO_ADDR_W-1:0] got,
		input logic [IO_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			n_fail++;
		end
	endtask

	task automatic check_iaddr(input string name, input logic [IADDR_W-1:0] got,
		input logic [IADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			n_fail++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			n_fail++;
		end
	endtask

	// Request fields must not move while io_req is up
	task automatic check_held(input logic wr, input logic [IO_ADDR_W-1:0] port,
		input logic [DATA_W-1:0] wdata);
		check_flag("io_wr", io_wr, wr);
		check_port("io_addr", io_addr, port);
		check_data("io_wdata", io_wdata, wdata);
	endtask

	// Expected port values follow the opcode rules, modulo 2^32
	task automatic build_expected(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		input logic [DATA_W-1:0] p5);
		xfer_val = '{a, b, a + b, a - b, a ^ b, a | b, a & b, p5};
	endtask

	// I/O responder --------------------

	// One four-phase transfer with random delays before each ack edge
	task automatic serve_io(input logic [DATA_W-1:0] rdata, output logic wr,
		output logic [IO_ADDR_W-1:0] port, output logic [DATA_W-1:0] wdata, output logic ok);
		int n;
		int dly;
		int start;
		logic [IADDR_W-1:0] pc;
		ok    = 1'b0;
		wr    = 1'b0;
		port  = '0;
		wdata = '0;
		n     = 0;
		while (!io_req && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (!io_req) begin
			$display("Timeout: the core never raised io_req");
			n_timeout++;
			return;
		end
		wr    = io_wr;
		port  = io_addr;
		wdata = io_wdata;
		pc    = instr_addr;
		start = cycle;
		dly   = $unsigned($random(seed)) % 4;
		repeat (dly) begin
			@(negedge clk);
			check_held(wr, port, wdata);
		end
		@(posedge clk);
		io_ack   <= 1'b1;
		io_rdata <= rdata;
		// Request must drop once ack is seen
		n = 0;
		while (io_req && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
			if (io_req)
				check_held(wr, port, wdata);
		end
		if (io_req) begin
			$display("Timeout: io_req stayed high after io_ack");
			n_timeout++;
			return;
		end
		dly = $unsigned($random(seed)) % 4;
		repeat (dly) @(negedge clk);
		@(posedge clk);
		io_ack <= 1'b0;
		// Retire shows as a new fetch address
		n = 0;
		while (instr_addr == pc && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (instr_addr == pc) begin
			$display("Timeout: the I/O instruction at 0x%h never retired", pc);
			n_timeout++;
			return;
		end
		if (cycle - start < 4) begin
			$display("Transfer retired after %0d cycles, fewer than four", cycle - start);
			n_fail++;
		end
		ok = 1'b1;
	endtask

	// Main sequence --------------------

	initial begin
		int r;
		int t;
		logic wr;
		logic [IO_ADDR_W-1:0] port;
		logic [DATA_W-1:0] val;
		logic ok;
		clk       = 1'b0;
		rst       = 1'b1;
		io_ack    = 1'b0;
		io_rdata  = '0;
		n_fail    = 0;
		n_timeout = 0;
		seed      = 32'h9a80;
		load_program();

		// Reset state, sampled before rst falls
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_iaddr("instr_addr", instr_addr, '0);
		check_flag("io_req", io_req, 1'b0);
		check_flag("mem_wr", mem_wr, 1'b0);
		@(posedge clk);
		rst <= 1'b0;

		ok = 1'b1;
		for (r = 0; r < N_ROWS && ok; r++) begin
			build_expected(tab_a[r], tab_b[r], tab_p5[r]);
			for (t = 0; t < N_XFER && ok; t++) begin
				serve_io(xfer_val[t], wr, port, val, ok);
				if (ok) begin
					check_flag("io_wr", wr, xfer_wr[t]);
					check_port("io_addr", port, xfer_port[t]);
					if (xfer_wr[t])
						check_data("io_wdata", val, xfer_val[t]);
				end
			end
			// Core is parked on the next INN, RAM still holds this row
			if (ok) begin
				check_data("mem[1]", ram[1], tab_a[r]);
				check_data("mem[2]", ram[2], tab_b[r]);
			end
		end

		$display("Errors: %0d value, %0d stray write, %0d timeout", n_fail, n_stray, n_timeout);
		if (ok && n_fail == 0 && n_stray == 0 && n_timeout == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* verilog/core_ifs.sv */
/*
 * Core interfaces
 * Execution controls from the decoder and branch requests to fetch
 */
`timescale 1ns/1ps

// Execution control --------------------

interface exec_ctrl_if import core_pkg::*; ();

	// Decoded controls
	logic [ALU_W-1:0]     alu_op;
	logic                 alu_en;
	logic                 push;
	logic [ACC_SEL_W-1:0] acc_sel;
	logic                 acc_load;
	logic                 mem_wr;
	logic [OPERAND_W-1:0] operand;
	logic                 io_start;
	logic                 io_write;

	// Back from the I/O port
	logic                 stall;
	logic [DATA_W-1:0]    io_rdata;

	modport decode (
		output alu_op, alu_en, push, acc_sel, acc_load, mem_wr,
		output operand, io_start, io_write
	);

	modport exec (
		input alu_op, alu_en, push, acc_sel, acc_load, mem_wr,
		input operand, io_start, io_write, stall, io_rdata
	);

	modport io (
		input  io_start, io_write, operand,
		output stall, io_rdata
	);

endinterface

// Branch requests ----------------------

interface branch_if import core_pkg::*; ();

	logic               jump;
	logic               call;
	logic               ret;
	logic [IADDR_W-1:0] target;

	modport decode (output jump, call, ret, target);
	modport fetch  (input  jump, call, ret, target);

endinterface

/* verilog/core_pkg.sv */
/*
 * Core package
 * Field widths, stack depths, opcodes and internal select codes
 * shared by the stack and accumulator processor core
 */
package core_pkg;

	// Instruction word --------------------
	localparam int OPCODE_W  = 7;
	localparam int OPERAND_W = 9;
	localparam int INSTR_W   = OPCODE_W + OPERAND_W;

	// Addresses and data
	localparam int IADDR_W   = 9;
	localparam int DADDR_W   = 9;
	localparam int DATA_W    = 32;
	localparam int IO_ADDR_W = 3;

	// Stacks
	localparam int RSTACK_DEPTH = 8;
	localparam int DSTACK_DEPTH = 8;
	localparam int RSP_W        = $clog2(RSTACK_DEPTH);
	localparam int DSP_W        = $clog2(DSTACK_DEPTH);

	// Opcodes -----------------------------
	localparam logic [OPCODE_W-1:0] OP_NOP = 7'd0;
	localparam logic [OPCODE_W-1:0] OP_LOD = 7'd1;
	localparam logic [OPCODE_W-1:0] OP_SET = 7'd2;
	localparam logic [OPCODE_W-1:0] OP_LDK = 7'd3;
	localparam logic [OPCODE_W-1:0] OP_PSH = 7'd4;
	localparam logic [OPCODE_W-1:0] OP_INN = 7'd5;
	localparam logic [OPCODE_W-1:0] OP_OUT = 7'd6;
	localparam logic [OPCODE_W-1:0] OP_ADD = 7'd7;
	localparam logic [OPCODE_W-1:0] OP_SUB = 7'd8;
	localparam logic [OPCODE_W-1:0] OP_AND = 7'd9;
	localparam logic [OPCODE_W-1:0] OP_ORR = 7'd10;
	localparam logic [OPCODE_W-1:0] OP_XOR = 7'd11;
	localparam logic [OPCODE_W-1:0] OP_JMP = 7'd13;
	localparam logic [OPCODE_W-1:0] OP_JIZ = 7'd14;
	localparam logic [OPCODE_W-1:0] OP_CAL = 7'd15;
	localparam logic [OPCODE_W-1:0] OP_RET = 7'd16;

	// ALU operation select
	localparam int ALU_W = 3;
	localparam logic [ALU_W-1:0] ALU_ADD = 3'd0;
	localparam logic [ALU_W-1:0] ALU_SUB = 3'd1;
	localparam logic [ALU_W-1:0] ALU_AND = 3'd2;
	localparam logic [ALU_W-1:0] ALU_ORR = 3'd3;
	localparam logic [ALU_W-1:0] ALU_XOR = 3'd4;

	// Accumulator source select
	localparam int ACC_SEL_W = 2;
	localparam logic [ACC_SEL_W-1:0] SEL_MEM = 2'd0;
	localparam logic [ACC_SEL_W-1:0] SEL_IMM = 2'd1;
	localparam logic [ACC_SEL_W-1:0] SEL_IO  = 2'd2;
	localparam logic [ACC_SEL_W-1:0] SEL_ALU = 2'd3;

	// I/O handshake FSM states
	localparam int IO_ST_W = 2;
	localparam logic [IO_ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [IO_ST_W-1:0] ST_REQ  = 2'd1;
	localparam logic [IO_ST_W-1:0] ST_REL  = 2'd2;
	localparam logic [IO_ST_W-1:0] ST_DONE = 2'd3;

endpackage

/* verilog/core_top.sv */
/*
 * Core top level
 * Fetch, decode, datapath and I/O port wired to plain external ports
 */
`timescale 1ns/1ps

module core_top import core_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	// Instruction ROM
	output logic [IADDR_W-1:0]   instr_addr,
	input  logic [INSTR_W-1:0]   instr,
	// Data RAM
	output logic [DADDR_W-1:0]   mem_addr,
	output logic [DATA_W-1:0]    mem_wdata,
	output logic                 mem_wr,
	input  logic [DATA_W-1:0]    mem_rdata,
	// I/O
	output logic                 io_req,
	output logic                 io_wr,
	output logic [IO_ADDR_W-1:0] io_addr,
	output logic [DATA_W-1:0]    io_wdata,
	input  logic [DATA_W-1:0]    io_rdata,
	input  logic                 io_ack
);

	logic              stall;
	logic              acc_zero;
	logic [DATA_W-1:0] acc;

	exec_ctrl_if ctl ();
	branch_if    br ();

	// Units --------------------

	instr_fetch u_fetch (
		.clk        (clk),
		.rst        (rst),
		.stall      (stall),
		.br         (br.fetch),
		.instr_addr (instr_addr)
	);

	instr_decode u_decode (
		.instr    (instr),
		.acc_zero (acc_zero),
		.ctl      (ctl.decode),
		.br       (br.decode)
	);

	data_path u_data (
		.clk       (clk),
		.rst       (rst),
		.ctl       (ctl.exec),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wr    (mem_wr),
		.acc       (acc),
		.acc_zero  (acc_zero)
	);

	io_port u_io (
		.clk      (clk),
		.rst      (rst),
		.ctl      (ctl.io),
		.acc      (acc),
		.io_req   (io_req),
		.io_wr    (io_wr),
		.io_addr  (io_addr),
		.io_wdata (io_wdata),
		.io_rdata (io_rdata),
		.io_ack   (io_ack),
		.stall    (stall)
	);

endmodule

/* verilog/data_path.sv */
/*
 * Datapath
 * Data stack, accumulator, five-operation ALU and data memory port
 */
`timescale 1ns/1ps

module data_path import core_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	exec_ctrl_if.exec          ctl,
	input  logic [DATA_W-1:0]  mem_rdata,
	output logic [DADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0]  mem_wdata,
	output logic               mem_wr,
	output logic [DATA_W-1:0]  acc,
	output logic               acc_zero
);

	logic [DSP_W-1:0]  dsp;
	logic [DATA_W-1:0] ds_top;
	logic [DATA_W-1:0] alu_out;
	logic [DATA_W-1:0] acc_next;

	logic [DATA_W-1:0] dstack [DSTACK_DEPTH];

	// Data stack --------------------

	// Top is read combinationally as the left ALU operand
	assign ds_top = dstack[dsp - DSP_W'(1)];

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			dsp <= '0;
		else if (!ctl.stall) begin
			if (ctl.push)
				dsp <= dsp + DSP_W'(1);
			else if (ctl.alu_en)
				dsp <= dsp - DSP_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!ctl.stall && ctl.push)
			dstack[dsp] <= acc;
	end

	// ALU --------------------

	always_comb begin
		case (ctl.alu_op)
			ALU_ADD: alu_out = ds_top + acc;
			ALU_SUB: alu_out = ds_top - acc;
			ALU_AND: alu_out = ds_top & acc;
			ALU_ORR: alu_out = ds_top | acc;
			ALU_XOR: alu_out = ds_top ^ acc;
			default: alu_out = '0;
		endcase
	end

	// Accumulator --------------------

	always_comb begin
		case (ctl.acc_sel)
			SEL_MEM: acc_next = mem_rdata;
			SEL_IMM: acc_next = DATA_W'(ctl.operand);
			SEL_IO:  acc_next = ctl.io_rdata;
			default: acc_next = alu_out;
		endcase
	end

	// Held during an open I/O transfer
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else if (!ctl.stall && ctl.acc_load)
			acc <= acc_next;
	end

	assign acc_zero = (acc == '0);

	// Memory port, direct address only
	assign mem_addr  = ctl.operand[DADDR_W-1:0];
	assign mem_wdata = acc;
	assign mem_wr    = ctl.mem_wr;

endmodule

/* verilog/instr_decode.sv */
/*
 * Instruction decoder
 * Maps the current opcode onto datapath, memory, I/O and branch controls
 */
`timescale 1ns/1ps

module instr_decode import core_pkg::*; (
	input  logic [INSTR_W-1:0] instr,
	input  logic               acc_zero,
	exec_ctrl_if.decode        ctl,
	branch_if.decode           br
);

	logic [OPCODE_W-1:0]  opcode;
	logic [OPERAND_W-1:0] operand;

	// Fixed field split
	assign opcode  = instr[INSTR_W-1 -: OPCODE_W];
	assign operand = instr[OPERAND_W-1:0];

	assign ctl.operand = operand;
	assign br.target   = operand[IADDR_W-1:0];

	// Opcode map --------------------

	always_comb begin
		// Anything not listed behaves as NOP
		ctl.alu_op   = ALU_ADD;
		ctl.alu_en   = 1'b0;
		ctl.push     = 1'b0;
		ctl.acc_sel  = SEL_MEM;
		ctl.acc_load = 1'b0;
		ctl.mem_wr   = 1'b0;
		ctl.io_start = 1'b0;
		ctl.io_write = 1'b0;
		br.jump      = 1'b0;
		br.call      = 1'b0;
		br.ret       = 1'b0;

		case (opcode)
			OP_LOD: begin
				ctl.acc_sel  = SEL_MEM;
				ctl.acc_load = 1'b1;
			end
			OP_SET: ctl.mem_wr = 1'b1;
			OP_LDK: begin
				ctl.acc_sel  = SEL_IMM;
				ctl.acc_load = 1'b1;
			end
			OP_PSH: ctl.push = 1'b1;
			// Port read lands in acc when the transfer retires
			OP_INN: begin
				ctl.io_start = 1'b1;
				ctl.acc_sel  = SEL_IO;
				ctl.acc_load = 1'b1;
			end
			OP_OUT: begin
				ctl.io_start = 1'b1;
				ctl.io_write = 1'b1;
			end
			OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_XOR: begin
				ctl.alu_en   = 1'b1;
				ctl.acc_sel  = SEL_ALU;
				ctl.acc_load = 1'b1;
				case (opcode)
					OP_SUB:  ctl.alu_op = ALU_SUB;
					OP_AND:  ctl.alu_op = ALU_AND;
					OP_ORR:  ctl.alu_op = ALU_ORR;
					OP_XOR:  ctl.alu_op = ALU_XOR;
					default: ctl.alu_op = ALU_ADD;
				endcase
			end
			OP_JMP: br.jump = 1'b1;
			OP_JIZ: br.jump = acc_zero;
			OP_CAL: br.call = 1'b1;
			OP_RET: br.ret  = 1'b1;
			default: ;
		endcase
	end

endmodule

/* verilog/instr_fetch.sv */
/*
 * Instruction fetch
 * Program counter, return-address stack and next-address select
 */
`timescale 1ns/1ps

module instr_fetch import core_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,
	branch_if.fetch            br,
	output logic [IADDR_W-1:0] instr_addr
);

	logic [IADDR_W-1:0] pc;
	logic [IADDR_W-1:0] pc_inc;
	logic [IADDR_W-1:0] pc_next;
	logic [IADDR_W-1:0] rs_top;
	logic [RSP_W-1:0]   rsp;

	// Return addresses
	logic [IADDR_W-1:0] rstack [RSTACK_DEPTH];

	// Next address --------------------

	assign pc_inc = pc + IADDR_W'(1);

	// Pointer sits one above the last pushed entry
	assign rs_top = rstack[rsp - RSP_W'(1)];

	always_comb begin
		if (br.ret)
			pc_next = rs_top;
		else if (br.jump || br.call)
			pc_next = br.target;
		else
			pc_next = pc_inc;
	end

	// PC and stack pointer --------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc  <= '0;
			rsp <= '0;
		end else if (!stall) begin
			pc <= pc_next;
			if (br.call)
				rsp <= rsp + RSP_W'(1);
			else if (br.ret)
				rsp <= rsp - RSP_W'(1);
		end
	end

	// Call saves the address after itself
	always_ff @(posedge clk) begin
		if (!stall && br.call)
			rstack[rsp] <= pc_inc;
	end

	assign instr_addr = pc;

endmodule

/* verilog/io_port.sv */
/*
 * I/O port
 * Four-phase req/ack handshake, stalls the core until the transfer retires
 */
`timescale 1ns/1ps

module io_port import core_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	exec_ctrl_if.io              ctl,
	input  logic [DATA_W-1:0]    acc,
	output logic                 io_req,
	output logic                 io_wr,
	output logic [IO_ADDR_W-1:0] io_addr,
	output logic [DATA_W-1:0]    io_wdata,
	input  logic [DATA_W-1:0]    io_rdata,
	input  logic                 io_ack,
	output logic                 stall
);

	logic [IO_ST_W-1:0] state;

	// Handshake FSM --------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= ST_IDLE;
			io_req  <= 1'b0;
			io_wr   <= 1'b0;
			io_addr <= '0;
		end else begin
			case (state)
				// Port and direction frozen for the whole request
				ST_IDLE: if (ctl.io_start) begin
					io_req  <= 1'b1;
					io_wr   <= ctl.io_write;
					io_addr <= ctl.operand[IO_ADDR_W-1:0];
					state   <= ST_REQ;
				end
				ST_REQ: if (io_ack) begin
					io_req <= 1'b0;
					state  <= ST_REL;
				end
				// Wait for responder to drop ack
				ST_REL: if (!io_ack)
					state <= ST_DONE;
				// Instruction retires at this edge
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Payload --------------------

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && ctl.io_start)
			io_wdata <= acc;
		if (state == ST_REQ && io_ack)
			ctl.io_rdata <= io_rdata;
	end

	// Hold the core from decode until done
	assign stall     = ctl.io_start && (state != ST_DONE);
	assign ctl.stall = stall;

endmodule
